// File: board_cfg_pkg.sv
// Game configuration definitions
// Bit positions in the host status word and the DIP settings
// handed to the game logic

package board_cfg_pkg;

    // Status word bit positions
    localparam int STAT_PAUSE_BIT = 1;
    localparam int STAT_LEVEL_LSB = 2;    // 2-bit field
    localparam int STAT_LIVES_LSB = 5;    // 2-bit field
    localparam int STAT_MIX_BIT   = 9;
    localparam int STAT_RESET_BIT = 15;

    // Difficulty codes as the game expects them
    typedef enum logic [1:0] {
        LEVEL_EASY   = 2'b00,
        LEVEL_NORMAL = 2'b01,
        LEVEL_HARD   = 2'b10,
        LEVEL_VHARD  = 2'b11
    } level_t;

    typedef struct packed {
        logic       pause;      // Active high runs the game
        level_t     level;
        logic [1:0] lives;
        logic       en_mixing;
        logic       upright;
    } dip_cfg_t;

endpackage

// File: board_bus_pkg.sv
// Host bus definitions
// AXI4-Lite channel payloads, the register map and the ROM
// download and game read ports

package board_bus_pkg;

    // Address fields below are sized for the largest ROM supported
    localparam int ROM_AW_MAX = 16;

    // Register offsets
    localparam logic [7:0] REG_STATUS   = 8'h00;
    localparam logic [7:0] REG_CTRL     = 8'h04;
    localparam logic [7:0] REG_ROM_ADDR = 8'h08;
    localparam logic [7:0] REG_ROM_DATA = 8'h0C;

    localparam int         CTRL_DL_BIT = 0;     // Download in progress
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    typedef struct packed {
        logic [7:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [7:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    // ROM byte write from the download port
    typedef struct packed {
        logic [ROM_AW_MAX-1:0] addr;
        logic [7:0]            data;
        logic                  we;
    } prog_wr_t;

    // Game word read request
    typedef struct packed {
        logic [ROM_AW_MAX-3:0] addr;
        logic                  req;
    } rom_rd_t;

endpackage

// File: cfg_axil_slave.sv
`timescale 1ns/100ps

// AXI4-Lite configuration slave
// Holds the status word, the control flags and the ROM address.
// Writes to the data register become single ROM byte writes

module cfg_axil_slave
    import board_bus_pkg::*;
#(
    parameter int ROM_AW = 12
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  axil_aw_t    aw,
    input  logic        awvalid,
    output logic        awready,
    input  axil_w_t     w,
    input  logic        wvalid,
    output logic        wready,
    output axil_b_t     b,
    output logic        bvalid,
    input  logic        bready,
    input  axil_ar_t    ar,
    input  logic        arvalid,
    output logic        arready,
    output axil_r_t     r,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] status,
    output logic        downloading,
    output prog_wr_t    prog
);

    logic              wr_start;
    logic              wr_hs;
    logic              rd_start;
    logic              rd_hs;
    logic [31:0]       ctrl;
    logic [ROM_AW-1:0] rom_addr;
    logic [ROM_AW-1:0] prog_addr;
    logic [7:0]        prog_data;
    logic              prog_we;
    logic [31:0]       rd_data;
    logic [31:0]       r_data;

    // Merge the write data into the old value lane by lane
    function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = new_val[8*i +: 8];
        end
        return res;
    endfunction

    // Both channels must be present and the last response taken
    assign wr_start = awvalid & wvalid & ~awready & ~bvalid;
    assign wr_hs    = awready & awvalid & wvalid;
    assign rd_start = arvalid & ~arready & ~rvalid;
    assign rd_hs    = arready & arvalid;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= wr_start;            // One cycle pulse
            wready  <= wr_start;
            if (wr_hs)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            status   <= '0;
            ctrl     <= '0;
            rom_addr <= '0;
            prog_we  <= 1'b0;
        end else begin
            prog_we <= 1'b0;
            if (wr_hs) begin
                case (aw.addr)
                    REG_STATUS:   status   <= apply_strb(status, w.data, w.strb);
                    REG_CTRL:     ctrl     <= apply_strb(ctrl, w.data, w.strb);
                    REG_ROM_ADDR: rom_addr <= w.data[ROM_AW-1:0];
                    REG_ROM_DATA: begin
                        prog_we  <= 1'b1;
                        rom_addr <= rom_addr + 1'b1;    // Next byte
                    end
                    default: ;                          // Ignored
                endcase
            end
        end
    end

    // Byte captured with the address in use before the increment
    always_ff @(posedge clk_sys) begin
        if (wr_hs && aw.addr == REG_ROM_DATA) begin
            prog_addr <= rom_addr;
            prog_data <= w.data[7:0];
        end
    end

    assign downloading = ctrl[CTRL_DL_BIT];
    assign prog        = '{addr: ROM_AW_MAX'(prog_addr), data: prog_data, we: prog_we};
    assign b           = '{resp: RESP_OKAY};

    always_comb begin
        case (ar.addr)
            REG_STATUS:   rd_data = status;
            REG_CTRL:     rd_data = ctrl;
            REG_ROM_ADDR: rd_data = 32'(rom_addr);
            default:      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= rd_start;
            if (rd_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rd_hs)
            r_data <= rd_data;
    end

    assign r = '{data: r_data, resp: RESP_OKAY};

endmodule

// File: dip_decoder.sv
`timescale 1ns/100ps

// DIP setting decoder
// Latches the host status word into the settings the game reads
// and registers the game reset request

module dip_decoder
    import board_cfg_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic [31:0] status,
    input  logic        game_pause,
    output dip_cfg_t    dip,
    output logic        game_rst
);

    dip_cfg_t dip_nxt;

    always_comb begin
        dip_nxt = '0;
        // Menu order differs from the game's own level codes
        case (status[STAT_LEVEL_LSB +: 2])
            2'b00: dip_nxt.level = LEVEL_NORMAL;
            2'b01: dip_nxt.level = LEVEL_EASY;
            2'b10: dip_nxt.level = LEVEL_HARD;
            2'b11: dip_nxt.level = LEVEL_VHARD;
        endcase
        dip_nxt.lives     = status[STAT_LIVES_LSB +: 2];
        dip_nxt.pause     = ~status[STAT_PAUSE_BIT] & ~game_pause;
        dip_nxt.en_mixing = ~status[STAT_MIX_BIT];    // Filter on when bit is clear
        dip_nxt.upright   = 1'b1;                     // No cocktail cabinet
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            dip      <= '0;
            game_rst <= 1'b0;
        end else begin
            dip      <= dip_nxt;
            game_rst <= status[STAT_RESET_BIT];
        end
    end

endmodule

// File: rom_loader_mem.sv
`timescale 1ns/100ps

// Game ROM in block memory
// Filled byte by byte from the download port and read by the
// game a 32-bit word at a time, little-endian

module rom_loader_mem
    import board_bus_pkg::*;
#(
    parameter int ROM_AW = 12
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  prog_wr_t    prog,
    input  logic        downloading,
    input  rom_rd_t     rd,
    output logic [31:0] rom_data,
    output logic        data_rdy
);

    localparam int WORDS = 2 ** (ROM_AW - 2);

    logic              rd_accept;
    logic              served;      // Request already answered
    logic [ROM_AW-3:0] wr_word;
    logic [1:0]        wr_lane;
    logic [ROM_AW-3:0] rd_word;
    logic [7:0]        lane_q [4];

    assign wr_word = prog.addr[ROM_AW-1:2];
    assign wr_lane = prog.addr[1:0];
    assign rd_word = rd.addr[ROM_AW-3:0];

    // Game waits while a download is running
    assign rd_accept = rd.req & ~downloading & ~served;

    // One bank per byte lane so a word reads in a single cycle
    for (genvar i = 0; i < 4; i++) begin : g_lane
        logic [7:0] bank [WORDS];

        always_ff @(posedge clk_sys) begin
            if (prog.we && wr_lane == 2'(i))
                bank[wr_word] <= prog.data;
            if (rd_accept)
                lane_q[i] <= bank[rd_word];
        end
    end

    assign rom_data = {lane_q[3], lane_q[2], lane_q[1], lane_q[0]};

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            data_rdy <= 1'b0;
            served   <= 1'b0;
        end else begin
            data_rdy <= rd_accept;
            if (rd_accept)
                served <= 1'b1;
            else if (!rd.req)
                served <= 1'b0;     // Game dropped req, ready for the next one
        end
    end

endmodule

// File: video_expander.sv
`timescale 1ns/100ps

// VGA colour expander
// Widens the game's 3-bit channels to 6 bits on each pixel enable
// and forces black during blanking

module video_expander (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic [2:0] red,
    input  logic [2:0] green,
    input  logic [2:0] blue,
    input  logic       hblank,
    input  logic       vblank,
    output logic [5:0] vga_r,
    output logic [5:0] vga_g,
    output logic [5:0] vga_b,
    output logic       vga_hs,
    output logic       vga_vs
);

    logic blank;

    // Repeat the top bits so full scale maps to full scale
    function automatic logic [5:0] expand(input logic [2:0] c);
        return {c, c[2], c[2:1]};
    endfunction

    assign blank = hblank | vblank;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
            vga_hs <= 1'b0;
            vga_vs <= 1'b0;
        end else if (pxl_cen) begin
            vga_r  <= blank ? 6'd0 : expand(red);
            vga_g  <= blank ? 6'd0 : expand(green);
            vga_b  <= blank ? 6'd0 : expand(blue);
            vga_hs <= hblank;       // Blanks stand in for sync
            vga_vs <= vblank;
        end
    end

endmodule

// File: arcade_board_top.sv
`timescale 1ns/100ps

// Arcade board wrapper top level
// Host register block, DIP decoder, ROM memory and video output
// stage around the game core

module arcade_board_top
    import board_bus_pkg::*;
    import board_cfg_pkg::*;
#(
    parameter int ROM_AW = 12       // Up to ROM_AW_MAX
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    // Host AXI4-Lite
    input  axil_aw_t    aw,
    input  logic        awvalid,
    output logic        awready,
    input  axil_w_t     w,
    input  logic        wvalid,
    output logic        wready,
    output axil_b_t     b,
    output logic        bvalid,
    input  logic        bready,
    input  axil_ar_t    ar,
    input  logic        arvalid,
    output logic        arready,
    output axil_r_t     r,
    output logic        rvalid,
    input  logic        rready,
    // Game side
    input  logic        game_pause,
    output dip_cfg_t    dip,
    output logic        game_rst,
    input  rom_rd_t     rd,
    output logic [31:0] rom_data,
    output logic        data_rdy,
    // Video
    input  logic        pxl_cen,
    input  logic [2:0]  red,
    input  logic [2:0]  green,
    input  logic [2:0]  blue,
    input  logic        hblank,
    input  logic        vblank,
    output logic [5:0]  vga_r,
    output logic [5:0]  vga_g,
    output logic [5:0]  vga_b,
    output logic        vga_hs,
    output logic        vga_vs
);

    logic [31:0] status;
    logic        downloading;
    prog_wr_t    prog;

    cfg_axil_slave #(
        .ROM_AW      ( ROM_AW      )
    ) u_cfg (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .aw          ( aw          ),
        .awvalid     ( awvalid     ),
        .awready     ( awready     ),
        .w           ( w           ),
        .wvalid      ( wvalid      ),
        .wready      ( wready      ),
        .b           ( b           ),
        .bvalid      ( bvalid      ),
        .bready      ( bready      ),
        .ar          ( ar          ),
        .arvalid     ( arvalid     ),
        .arready     ( arready     ),
        .r           ( r           ),
        .rvalid      ( rvalid      ),
        .rready      ( rready      ),
        .status      ( status      ),
        .downloading ( downloading ),
        .prog        ( prog        )
    );

    dip_decoder u_dip (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .status      ( status      ),
        .game_pause  ( game_pause  ),
        .dip         ( dip         ),
        .game_rst    ( game_rst    )
    );

    rom_loader_mem #(
        .ROM_AW      ( ROM_AW      )
    ) u_rom (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .prog        ( prog        ),
        .downloading ( downloading ),
        .rd          ( rd          ),
        .rom_data    ( rom_data    ),
        .data_rdy    ( data_rdy    )
    );

    video_expander u_video (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pxl_cen     ( pxl_cen     ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .hblank      ( hblank      ),
        .vblank      ( vblank      ),
        .vga_r       ( vga_r       ),
        .vga_g       ( vga_g       ),
        .vga_b       ( vga_b       ),
        .vga_hs      ( vga_hs      ),
        .vga_vs      ( vga_vs      )
    );

endmodule

// File: tb_arcade_board.sv
`timescale 1ns/100ps

// Arcade board wrapper testbench
// Table-driven AXI4-Lite register and DIP checks, then ROM download,
// game reads and VGA expansion against a local model

module tb_arcade_board
    import board_bus_pkg::*;
    import board_cfg_pkg::*;
;

    localparam int ROM_AW    = 12;
    localparam int MAX_STEPS = 32;
    localparam int ROM_BYTES = 64;

    // Table operations
    localparam logic [2:0] OP_WR    = 3'd0;
    localparam logic [2:0] OP_RD    = 3'd1;
    localparam logic [2:0] OP_DIP   = 3'd2;   // addr[0] is game_pause
    localparam logic [2:0] OP_GRST  = 3'd3;
    localparam logic [2:0] OP_STALL = 3'd4;   // data then exp_val, bready low
    localparam logic [2:0] OP_END   = 3'd5;   // data is the test number

    typedef struct packed {
        logic [2:0]  op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] exp_val;
    } step_t;

    logic        clk_sys = 1'b0;
    logic        rst_n;
    axil_aw_t    aw;
    logic        awvalid;
    logic        awready;
    axil_w_t     w;
    logic        wvalid;
    logic        wready;
    axil_b_t     b;
    logic        bvalid;
    logic        bready;
    axil_ar_t    ar;
    logic        arvalid;
    logic        arready;
    axil_r_t     r;
    logic        rvalid;
    logic        rready;
    logic        game_pause;
    dip_cfg_t    dip;
    logic        game_rst;
    rom_rd_t     rd;
    logic [31:0] rom_data;
    logic        data_rdy;
    logic        pxl_cen;
    logic [2:0]  red;
    logic [2:0]  green;
    logic [2:0]  blue;
    logic        hblank;
    logic        vblank;
    logic [5:0]  vga_r;
    logic [5:0]  vga_g;
    logic [5:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;

    step_t       steps [MAX_STEPS];
    int          n_steps     = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 4000;
    int          test_errs   = 0;
    int          tests_ok    = 0;
    int          tests_bad   = 0;
    integer      seed        = 40146;
    logic [7:0]  rom_model [ROM_BYTES];
    step_t       st;
    logic [31:0] got;
    logic [31:0] rnd;
    logic [31:0] exp_word;
    int          n;
    logic [5:0]  exp_r;
    logic [5:0]  exp_g;
    logic [5:0]  exp_b;
    logic        exp_hs;
    logic        exp_vs;

    arcade_board_top #(
        .ROM_AW ( ROM_AW )
    ) uut (.*);

    always #50 clk_sys = ~clk_sys;

    // Watchdog
    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic report_err(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        $display("FAIL %0t %s expected %h got %h", $time, name, exp_v, act_v);
        test_errs++;
    endtask

    task automatic report_msg(input string msg);
        $display("ERROR %0t %s", $time, msg);
        test_errs++;
    endtask

    function automatic string test_name(input int idx);
        case (idx)
            1:       return "registers";
            2:       return "dip decode";
            3:       return "game reset";
            default: return "unnamed";
        endcase
    endfunction

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    task automatic add_step(input logic [2:0] op, input logic [7:0] addr,
                            input logic [31:0] data, input logic [31:0] exp_val);
        steps[n_steps] = {op, addr, data, exp_val};
        n_steps++;
    endtask

    task automatic wait_write_hs();
        @(negedge clk_sys);
        while (!(awready && wready))
            @(negedge clk_sys);
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk_sys);
        aw      <= addr;
        w       <= {data, 4'hF};
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        wait_write_hs();
        @(posedge clk_sys);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk_sys);
        while (!bvalid)
            @(negedge clk_sys);
        if (b.resp !== RESP_OKAY)
            report_err("b.resp", RESP_OKAY, b.resp);
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk_sys);
        ar      <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        @(negedge clk_sys);
        while (!arready)
            @(negedge clk_sys);
        @(posedge clk_sys);
        arvalid <= 1'b0;
        @(negedge clk_sys);
        while (!rvalid)
            @(negedge clk_sys);
        data = r.data;
        if (r.resp !== RESP_OKAY)
            report_err("r.resp", RESP_OKAY, r.resp);
    endtask

    // Second write sits on the bus while B is back-pressured
    task automatic stall_write(input logic [7:0] addr, input logic [31:0] first,
                               input logic [31:0] second);
        @(posedge clk_sys);
        aw      <= addr;
        w       <= {first, 4'hF};
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b0;
        wait_write_hs();
        @(posedge clk_sys);
        w <= {second, 4'hF};
        repeat (4) begin
            @(negedge clk_sys);
            if (bvalid !== 1'b1)
                report_err("bvalid", 1, bvalid);
            if (awready !== 1'b0)
                report_err("awready", 0, awready);
        end
        @(posedge clk_sys);
        bready <= 1'b1;
        wait_write_hs();
        @(posedge clk_sys);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk_sys);
        while (!bvalid)
            @(negedge clk_sys);
    endtask

    // Request must be answered on the second edge, once only
    task automatic game_read(input logic [13:0] word);
        logic [31:0] exp_v;
        exp_v = {rom_model[4*word+3], rom_model[4*word+2],
                 rom_model[4*word+1], rom_model[4*word]};
        @(posedge clk_sys);
        rd <= {word, 1'b1};
        @(negedge clk_sys);
        if (data_rdy !== 1'b0)
            report_err("data_rdy", 0, data_rdy);
        @(negedge clk_sys);
        if (data_rdy !== 1'b1)
            report_err("data_rdy", 1, data_rdy);
        else if (rom_data !== exp_v)
            report_err("rom_data", exp_v, rom_data);
        @(posedge clk_sys);
        rd <= '0;
        @(negedge clk_sys);
        if (data_rdy !== 1'b0)
            report_err("data_rdy", 0, data_rdy);
    endtask

    function automatic logic [5:0] widen(input logic [2:0] c);
        return {c[2], c[1], c[0], c[2], c[2], c[1]};
    endfunction

    task automatic check_video();
        if (vga_r !== exp_r)
            report_err("vga_r", exp_r, vga_r);
        if (vga_g !== exp_g)
            report_err("vga_g", exp_g, vga_g);
        if (vga_b !== exp_b)
            report_err("vga_b", exp_b, vga_b);
        if (vga_hs !== exp_hs)
            report_err("vga_hs", exp_hs, vga_hs);
        if (vga_vs !== exp_vs)
            report_err("vga_vs", exp_vs, vga_vs);
    endtask

    initial begin
        rst_n      = 1'b0;
        aw         = '0;
        awvalid    = 1'b0;
        w          = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        ar         = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        game_pause = 1'b0;
        rd         = '0;
        pxl_cen    = 1'b0;
        red        = '0;
        green      = '0;
        blue       = '0;
        hblank     = 1'b0;
        vblank     = 1'b0;

        // Register map
        add_step(OP_RD,    REG_STATUS,   32'h0,        32'h0);
        add_step(OP_WR,    REG_STATUS,   32'h5A5A1234, 32'h0);
        add_step(OP_RD,    REG_STATUS,   32'h0,        32'h5A5A1234);
        add_step(OP_WR,    REG_CTRL,     32'h00000100, 32'h0);
        add_step(OP_RD,    REG_CTRL,     32'h0,        32'h00000100);
        add_step(OP_WR,    REG_ROM_ADDR, 32'h00000123, 32'h0);
        add_step(OP_RD,    REG_ROM_ADDR, 32'h0,        32'h00000123);
        add_step(OP_WR,    8'h10,        32'hDEADBEEF, 32'h0);
        add_step(OP_RD,    8'h10,        32'h0,        32'h0);
        add_step(OP_STALL, REG_STATUS,   32'h000000F0, 32'h00000F00);
        add_step(OP_END,   8'h00,        32'd1,        32'h0);
        // Level and lives codes, pause and mixing
        add_step(OP_DIP,   8'h00,        32'h00000000, 32'h53);
        add_step(OP_DIP,   8'h00,        32'h00000024, 32'h47);
        add_step(OP_DIP,   8'h00,        32'h0000004A, 32'h2B);
        add_step(OP_DIP,   8'h00,        32'h0000026C, 32'h7D);
        add_step(OP_DIP,   8'h01,        32'h00000000, 32'h13);
        add_step(OP_DIP,   8'h00,        32'h00000200, 32'h51);
        add_step(OP_END,   8'h00,        32'd2,        32'h0);
        add_step(OP_GRST,  8'h00,        32'h00008000, 32'h1);
        add_step(OP_GRST,  8'h00,        32'h00000000, 32'h0);
        add_step(OP_END,   8'h00,        32'd3,        32'h0);
        cycle_limit = 20 * n_steps + 4000;

        repeat (4) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);
        if ({awready, wready, arready, bvalid, rvalid, data_rdy, game_rst} !== 7'b0)
            report_err("{awready,wready,arready,bvalid,rvalid,data_rdy,game_rst}", 0,
                       {25'd0, awready, wready, arready, bvalid, rvalid, data_rdy, game_rst});
        if ({vga_r, vga_g, vga_b, vga_hs, vga_vs} !== 20'b0)
            report_err("{vga_r,vga_g,vga_b,vga_hs,vga_vs}", 0,
                       {12'd0, vga_r, vga_g, vga_b, vga_hs, vga_vs});
        end_test("reset values");

        for (int i = 0; i < n_steps; i++) begin
            st = steps[i];
            case (st.op)
                OP_WR: axi_write(st.addr, st.data);
                OP_RD: begin
                    axi_read(st.addr, got);
                    if (got !== st.exp_val)
                        report_err($sformatf("r.data@%h", st.addr), st.exp_val, got);
                end
                OP_DIP: begin
                    @(posedge clk_sys);
                    game_pause <= st.addr[0];
                    axi_write(REG_STATUS, st.data);
                    @(negedge clk_sys);                 // Register plus decoder stage
                    if (dip !== st.exp_val[6:0])
                        report_err("dip", st.exp_val, {25'd0, dip});
                end
                OP_GRST: begin
                    axi_write(REG_STATUS, st.data);
                    @(negedge clk_sys);
                    if (game_rst !== st.exp_val[0])
                        report_err("game_rst", st.exp_val, game_rst);
                end
                OP_STALL: begin
                    stall_write(st.addr, st.data, st.exp_val);
                    axi_read(st.addr, got);
                    if (got !== st.exp_val)
                        report_err($sformatf("r.data@%h", st.addr), st.exp_val, got);
                end
                default: end_test(test_name(st.data));
            endcase
        end

        // Download 64 bytes, then read every word back
        axi_write(REG_CTRL, 32'h1);
        axi_write(REG_ROM_ADDR, 32'h0);
        for (int i = 0; i < ROM_BYTES; i++) begin
            rnd = $random(seed);
            rom_model[i] = rnd[7:0];
            axi_write(REG_ROM_DATA, {24'h0, rom_model[i]});
        end
        axi_read(REG_ROM_ADDR, got);
        if (got !== ROM_BYTES)
            report_err("r.data@08", ROM_BYTES, got);
        axi_write(REG_CTRL, 32'h0);
        for (int i = 0; i < ROM_BYTES / 4; i++)
            game_read(i);
        end_test("rom download");

        // Request held off by the download flag
        axi_write(REG_CTRL, 32'h1);
        exp_word = {rom_model[23], rom_model[22], rom_model[21], rom_model[20]};
        @(posedge clk_sys);
        rd <= {14'd5, 1'b1};
        repeat (8) begin
            @(negedge clk_sys);
            if (data_rdy !== 1'b0)
                report_err("data_rdy", 0, data_rdy);
        end
        axi_write(REG_CTRL, 32'h0);
        n = 0;
        @(negedge clk_sys);
        while (!data_rdy && n < 10) begin
            @(negedge clk_sys);
            n++;
        end
        if (!data_rdy)
            report_msg("no data_rdy after the download flag was cleared");
        else if (rom_data !== exp_word)
            report_err("rom_data", exp_word, rom_data);
        @(posedge clk_sys);
        rd <= '0;
        end_test("download hold");

        // Random pixels, enables and blanking
        exp_r  = '0;
        exp_g  = '0;
        exp_b  = '0;
        exp_hs = 1'b0;
        exp_vs = 1'b0;
        for (int i = 0; i < 48; i++) begin
            @(posedge clk_sys);
            rnd = $random(seed);
            pxl_cen <= rnd[9] | rnd[10];
            red     <= rnd[2:0];
            green   <= rnd[5:3];
            blue    <= rnd[8:6];
            hblank  <= rnd[11] & rnd[12];
            vblank  <= rnd[13] & rnd[14] & rnd[15];
            @(negedge clk_sys);
            check_video();                      // Shows the previous enable
            if (rnd[9] | rnd[10]) begin
                exp_hs = rnd[11] & rnd[12];
                exp_vs = rnd[13] & rnd[14] & rnd[15];
                exp_r  = (exp_hs | exp_vs) ? 6'd0 : widen(rnd[2:0]);
                exp_g  = (exp_hs | exp_vs) ? 6'd0 : widen(rnd[5:3]);
                exp_b  = (exp_hs | exp_vs) ? 6'd0 : widen(rnd[8:6]);
            end
        end
        @(posedge clk_sys);
        pxl_cen <= 1'b0;
        repeat (2) begin
            @(negedge clk_sys);
            check_video();
        end
        end_test("video");

        $display("%0d tests passed, %0d tests failed", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: compile.f
board_cfg_pkg.sv
board_bus_pkg.sv
cfg_axil_slave.sv
dip_decoder.sv
rom_loader_mem.sv
video_expander.sv
arcade_board_top.sv
tb_arcade_board.sv
